/* source/stream_pkg.sv */
`default_nettype none

package stream_pkg;

  localparam int data_w = 32;
  localparam int strb_w = data_w / 8;

  // ready pattern width, one bit per cycle slot.
  localparam int ready_mask_w = 4;

  localparam int apb_addr_w = 4;

  typedef struct packed {
    logic [data_w-1:0] data;
    logic [strb_w-1:0] strb;
    logic              last;
  } axis_beat_t;

  typedef struct packed {
    logic [apb_addr_w-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [data_w-1:0]     pwdata;
  } apb_req_t;

  // register byte offsets.
  localparam logic [apb_addr_w-1:0] reg_ctrl   = 4'h0;
  localparam logic [apb_addr_w-1:0] reg_bursts = 4'h4;
  localparam logic [apb_addr_w-1:0] reg_errors = 4'h8;
  localparam logic [apb_addr_w-1:0] reg_last   = 4'hc;

endpackage : stream_pkg

`default_nettype wire

/* source/burst_source.sv */
`timescale 1ns/100ps
`default_nettype none

module burst_source #(
  parameter int start_count = 32,
  parameter int burst_len   = 8
) (
  input  wire                    M_AXIS_ACLK,
  input  wire                    M_AXIS_ARESETN,
  input  logic                   src_ready,
  output logic                   src_valid,
  output stream_pkg::axis_beat_t src_beat
);

  localparam int delay_w = $clog2(start_count + 1);
  localparam int beat_w  = $clog2(burst_len + 1);

  typedef enum logic [1:0] {
    st_idle,
    st_wait,
    st_send
  } state_t;

  state_t             state;
  logic [delay_w-1:0] delay_cnt;
  logic [beat_w-1:0]  beat_cnt; // index of the beat on the bus, 1 based.
  logic               xfer;

  assign xfer = src_valid && src_ready;

  // control path.
  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      state     <= st_idle;
      delay_cnt <= '0;
      beat_cnt  <= '0;
      src_valid <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          delay_cnt <= '0;
          state     <= st_wait;
        end
        st_wait: begin
          if (delay_cnt == delay_w'(start_count - 1)) begin
            state     <= st_send;
            src_valid <= 1'b1;
            beat_cnt  <= beat_w'(1);
          end else begin
            delay_cnt <= delay_cnt + 1'b1;
          end
        end
        st_send: begin
          if (xfer) begin
            if (src_beat.last) begin
              src_valid <= 1'b0;
              state     <= st_idle;
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // beat register, loaded on entry to send and on every accepted beat.
  always_ff @(posedge M_AXIS_ACLK) begin
    if (state == st_wait && delay_cnt == delay_w'(start_count - 1)) begin
      src_beat.data <= stream_pkg::data_w'(1);
      src_beat.strb <= '1;
      src_beat.last <= (burst_len == 1);
    end else if (xfer && !src_beat.last) begin
      src_beat.data <= stream_pkg::data_w'(beat_cnt) + 1'b1;
      src_beat.last <= (beat_cnt == beat_w'(burst_len - 1)); // next one closes the burst.
    end
  end

endmodule : burst_source

`default_nettype wire

/* source/beat_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module beat_fifo #(
  parameter type beat_t     = logic [7:0],
  parameter int  fifo_depth = 4
) (
  input  wire   M_AXIS_ACLK,
  input  wire   M_AXIS_ARESETN,
  input  logic  in_valid,
  input  beat_t in_data,
  output logic  in_ready,
  output logic  out_valid,
  output beat_t out_data,
  input  logic  out_ready
);

  localparam int addr_w = $clog2(fifo_depth);

  beat_t           mem [fifo_depth];
  logic [addr_w:0] wr_ptr; // extra msb tells full from empty.
  logic [addr_w:0] rd_ptr;
  logic            full;
  logic            empty;
  logic            push;
  logic            pop;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                 (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);

  assign in_ready  = !full;
  assign out_valid = !empty;
  assign out_data  = mem[rd_ptr[addr_w-1:0]];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge M_AXIS_ACLK) begin
    if (push) begin
      mem[wr_ptr[addr_w-1:0]] <= in_data;
    end
  end

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule : beat_fifo

`default_nettype wire

/* source/burst_sink.sv */
`timescale 1ns/100ps
`default_nettype none

module burst_sink #(
  parameter int burst_len = 8
) (
  input  wire                    M_AXIS_ACLK,
  input  wire                    M_AXIS_ARESETN,
  input  logic                   snk_valid,
  input  stream_pkg::axis_beat_t snk_beat,
  output logic                   snk_ready,
  input  stream_pkg::apb_req_t   apb,
  output logic [31:0]            prdata,
  output logic                   pready,
  output logic                   pslverr
);

  localparam int slot_w = $clog2(stream_pkg::ready_mask_w);

  logic [stream_pkg::ready_mask_w-1:0] ready_mask;
  logic [slot_w-1:0]                   slot;
  logic [stream_pkg::data_w-1:0]       expected;
  logic [31:0]                         burst_cnt;
  logic [31:0]                         error_cnt;
  logic [stream_pkg::data_w-1:0]       last_data;
  logic                                accept;
  logic                                beat_bad;
  logic                                apb_setup;
  logic                                apb_access;
  logic                                addr_ok;
  logic                                access_err;
  logic [31:0]                         rd_value;

  // back-pressure from the mask, one bit per cycle.
  assign snk_ready = ready_mask[slot];
  assign accept    = snk_valid && snk_ready;

  assign beat_bad = (snk_beat.data != expected) ||
                    (snk_beat.last != (expected == stream_pkg::data_w'(burst_len))) ||
                    (snk_beat.strb != '1);

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      slot      <= '0;
      expected  <= stream_pkg::data_w'(1);
      burst_cnt <= '0;
      error_cnt <= '0;
      last_data <= '0;
    end else begin
      slot <= slot + 1'b1;
      if (accept) begin
        last_data <= snk_beat.data;
        expected  <= snk_beat.last ? stream_pkg::data_w'(1) : expected + 1'b1;
        if (beat_bad && error_cnt != '1) error_cnt <= error_cnt + 1'b1;
        if (snk_beat.last && burst_cnt != '1) burst_cnt <= burst_cnt + 1'b1; // saturates.
      end
    end
  end

  // apb decode.
  assign apb_setup  = apb.psel && !apb.penable;
  assign apb_access = apb.psel && apb.penable;
  assign addr_ok    = (apb.paddr[1:0] == 2'b00);
  assign access_err = !addr_ok || (apb.pwrite && apb.paddr != stream_pkg::reg_ctrl);
  assign pready     = 1'b1; // no wait states.

  always_comb begin
    case (apb.paddr)
      stream_pkg::reg_ctrl:   rd_value = 32'(ready_mask);
      stream_pkg::reg_bursts: rd_value = burst_cnt;
      stream_pkg::reg_errors: rd_value = error_cnt;
      stream_pkg::reg_last:   rd_value = last_data;
      default:                rd_value = '0;
    endcase
  end

  // response is sampled in setup, presented through the access phase.
  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      prdata  <= '0;
      pslverr <= 1'b0;
    end else if (apb_setup) begin
      prdata  <= apb.pwrite ? '0 : rd_value;
      pslverr <= access_err;
    end else begin
      prdata  <= '0;
      pslverr <= 1'b0;
    end
  end

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      ready_mask <= '1;
    end else if (apb_access && apb.pwrite && apb.paddr == stream_pkg::reg_ctrl) begin
      ready_mask <= apb.pwdata[stream_pkg::ready_mask_w-1:0];
    end
  end

endmodule : burst_sink

`default_nettype wire

/* source/stream_top.sv */
`timescale 1ns/100ps
`default_nettype none

module stream_top #(
  parameter int start_count = 32,
  parameter int burst_len   = 8,
  parameter int fifo_depth  = 4
) (
  input  wire                  M_AXIS_ACLK,
  input  wire                  M_AXIS_ARESETN,
  input  stream_pkg::apb_req_t apb,
  output logic [31:0]          prdata,
  output logic                 pready,
  output logic                 pslverr
);

  logic                   src_valid;
  logic                   src_ready;
  stream_pkg::axis_beat_t src_beat;
  logic                   snk_valid;
  logic                   snk_ready;
  stream_pkg::axis_beat_t snk_beat;

  burst_source #(
    .start_count (start_count),
    .burst_len   (burst_len)
  ) u_source (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .src_ready      (src_ready),
    .src_valid      (src_valid),
    .src_beat       (src_beat)
  );

  beat_fifo #(
    .beat_t     (stream_pkg::axis_beat_t),
    .fifo_depth (fifo_depth)
  ) u_fifo (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .in_valid       (src_valid),
    .in_data        (src_beat),
    .in_ready       (src_ready),
    .out_valid      (snk_valid),
    .out_data       (snk_beat),
    .out_ready      (snk_ready)
  );

  burst_sink #(
    .burst_len (burst_len)
  ) u_sink (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .snk_valid      (snk_valid),
    .snk_beat       (snk_beat),
    .snk_ready      (snk_ready),
    .apb            (apb),
    .prdata         (prdata),
    .pready         (pready),
    .pslverr        (pslverr)
  );

endmodule : stream_top

`default_nettype wire

/* tests/stream_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module stream_sva #(
  parameter int width = 37
) (
  input wire             clk,
  input wire             rst_n,
  input wire             valid,
  input wire             ready,
  input wire [width-1:0] payload,
  input wire             psel,
  input wire             penable
);

  a_beat_held: assert property (@(posedge clk) disable iff (!rst_n)
    valid && !ready |=> valid && $stable(payload))
    else $error("beat changed or withdrawn before its transfer");

  a_valid_reset: assert property (@(posedge clk) !rst_n |=> !valid)
    else $error("valid high right after reset");

  // access phase only straight after setup.
  a_access_after_setup: assert property (@(posedge clk) disable iff (!rst_n)
    penable |-> psel && $past(psel && !penable))
    else $error("penable high without a setup phase before it");

endmodule : stream_sva

bind burst_source stream_sva #(.width($bits(stream_pkg::axis_beat_t))) u_src_sva (
  .clk (M_AXIS_ACLK), .rst_n (M_AXIS_ARESETN), .valid (src_valid), .ready (src_ready),
  .payload (src_beat), .psel (1'b0), .penable (1'b0)
);

bind beat_fifo stream_sva #(.width($bits(stream_pkg::axis_beat_t))) u_out_sva (
  .clk (M_AXIS_ACLK), .rst_n (M_AXIS_ARESETN), .valid (out_valid), .ready (out_ready),
  .payload (out_data), .psel (1'b0), .penable (1'b0)
);

bind burst_sink stream_sva #(.width($bits(stream_pkg::axis_beat_t))) u_apb_sva (
  .clk (M_AXIS_ACLK), .rst_n (M_AXIS_ARESETN), .valid (1'b0), .ready (1'b1),
  .payload ('0), .psel (apb.psel), .penable (apb.penable)
);

`default_nettype wire

/* tests/stream_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module stream_tb;

  localparam int burst_len  = 8;
  localparam int poll_limit = 400; // three cycles per read.

  logic                 M_AXIS_ACLK;
  logic                 M_AXIS_ARESETN;
  stream_pkg::apb_req_t apb;
  logic [31:0]          prdata;
  logic                 pready;
  logic                 pslverr;
  int                   error_count;
  int                   timeout_count;
  integer               seed;
  logic [31:0]          bursts_seen; // highest reg_bursts value read so far.

  stream_top #(
    .start_count (8),
    .burst_len   (burst_len),
    .fifo_depth  (4)
  ) dut (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .apb            (apb),
    .prdata         (prdata),
    .pready         (pready),
    .pslverr        (pslverr)
  );

  always #4 M_AXIS_ACLK = ~M_AXIS_ACLK;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h",
               $time, name, expected, actual);
      error_count++;
    end
  endtask

  // setup cycle, access cycle, response taken mid access.
  task automatic bus_cycle(input logic [3:0] addr, input logic write,
                           input logic [31:0] wdata, output logic [31:0] rdata,
                           output logic err);
    @(posedge M_AXIS_ACLK);
    apb.paddr   <= addr;
    apb.pwrite  <= write;
    apb.pwdata  <= wdata;
    apb.psel    <= 1'b1;
    apb.penable <= 1'b0;
    @(posedge M_AXIS_ACLK);
    apb.penable <= 1'b1;
    @(negedge M_AXIS_ACLK);
    rdata = prdata;
    err   = pslverr;
    check_value("pready", 1, pready);
    @(posedge M_AXIS_ACLK);
    apb.psel    <= 1'b0;
    apb.penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] ignored;
    bus_cycle(addr, 1'b1, data, ignored, err);
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
    bus_cycle(addr, 1'b0, '0, data, err);
  endtask

  task automatic read_reg(input logic [3:0] addr, input string name, output logic [31:0] data);
    logic err;
    apb_read(addr, data, err);
    check_value({"pslverr on ", name}, 0, err);
  endtask

  task automatic expect_reg(input logic [3:0] addr, input string name,
                            input logic [31:0] expected);
    logic [31:0] value;
    read_reg(addr, name, value);
    check_value(name, expected, value);
  endtask

  task automatic write_mask(input logic [3:0] mask);
    logic err;
    apb_write(stream_pkg::reg_ctrl, 32'(mask), err);
    check_value("pslverr on reg_ctrl", 0, err);
  endtask

  // polls a register until it reaches min_value.
  task automatic wait_at_least(input logic [3:0] addr, input string name,
                               input logic [31:0] min_value, output logic [31:0] value);
    int polls;
    polls = 0;
    read_reg(addr, name, value);
    while (value < min_value && polls < poll_limit) begin
      read_reg(addr, name, value);
      polls++;
    end
    if (value < min_value) begin
      $display("Timeout: %s stayed below %0d for %0d reads", name, min_value, poll_limit);
      timeout_count++;
    end
  endtask

  // a few bursts under one mask, checked at a burst boundary.
  task automatic run_bursts(input logic [3:0] mask, input int count);
    logic [31:0] base;
    logic [31:0] value;
    write_mask(mask);
    read_reg(stream_pkg::reg_bursts, "reg_bursts", base);
    assert (base >= bursts_seen) else begin
      $display("** Error at %0t ns: reg_bursts expected >= 0x%0h, got 0x%0h",
               $time, bursts_seen, base);
      error_count++;
    end
    wait_at_least(stream_pkg::reg_bursts, "reg_bursts", base + count, bursts_seen);
    wait_at_least(stream_pkg::reg_last, "reg_last", burst_len, value);
    check_value("reg_last", burst_len, value);
    expect_reg(stream_pkg::reg_errors, "reg_errors", 0);
  endtask

  task automatic reset_defaults();
    expect_reg(stream_pkg::reg_last, "reg_last", 0); // first, before any beat lands.
    expect_reg(stream_pkg::reg_errors, "reg_errors", 0);
    expect_reg(stream_pkg::reg_bursts, "reg_bursts", 0);
    expect_reg(stream_pkg::reg_ctrl, "reg_ctrl", 32'hf);
  endtask

  task automatic full_rate();
    run_bursts(4'hf, 3);
  endtask

  task automatic back_pressure();
    logic [3:0] mask;
    run_bursts(4'b0001, 2);
    repeat (4) begin
      mask = 4'($random(seed));
      if (mask == 4'h0)
        mask = 4'b0100;
      run_bursts(mask, 2);
    end
  endtask

  task automatic stall_and_resume();
    logic [31:0] held;
    write_mask(4'h0);
    read_reg(stream_pkg::reg_bursts, "reg_bursts", held);
    repeat (67) begin // about 200 cycles.
      expect_reg(stream_pkg::reg_bursts, "reg_bursts", held);
    end
    write_mask(4'hf);
    wait_at_least(stream_pkg::reg_bursts, "reg_bursts", held + 1, bursts_seen);
  endtask

  task automatic register_access();
    logic [31:0] held;
    logic [31:0] value;
    logic        err;
    write_mask(4'ha);
    expect_reg(stream_pkg::reg_ctrl, "reg_ctrl", 32'ha);
    apb_write(stream_pkg::reg_ctrl, 32'hffff_fff3, err);
    check_value("pslverr on reg_ctrl", 0, err);
    expect_reg(stream_pkg::reg_ctrl, "reg_ctrl", 32'h3);
    write_mask(4'h0); // freezes the counters.
    read_reg(stream_pkg::reg_bursts, "reg_bursts", held);
    apb_write(stream_pkg::reg_bursts, 32'h5a5a_0001, err);
    check_value("pslverr on reg_bursts write", 1, err);
    expect_reg(stream_pkg::reg_bursts, "reg_bursts", held);
    apb_read(4'h6, value, err); // no register here.
    check_value("pslverr on offset 0x6", 1, err);
    apb_write(4'hd, 32'h0000_000f, err);
    check_value("pslverr on offset 0xd", 1, err);
    expect_reg(stream_pkg::reg_ctrl, "reg_ctrl", 32'h0);
    write_mask(4'hf);
  endtask

  initial begin
    M_AXIS_ACLK = 1'b0;
    M_AXIS_ARESETN <= 1'b0;
    apb            <= '0;
    error_count   = 0;
    timeout_count = 0;
    seed          = 32'h0a7f74a4;
    bursts_seen   = '0;
    repeat (16) @(posedge M_AXIS_ACLK);
    M_AXIS_ARESETN <= 1'b1;
    reset_defaults();
    full_rate();
    back_pressure();
    stall_and_resume();
    register_access();
    $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule : stream_tb

`default_nettype wire

/* filelist.f */
source/stream_pkg.sv
source/burst_source.sv
source/beat_fifo.sv
source/burst_sink.sv
source/stream_top.sv
tests/stream_sva.sv
tests/stream_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = stream_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG) || ! grep -q "RESULT: PASS" $(LOG); then \
	  echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
